//--- video_pkg.sv
package video_pkg;

    ////////////////////
    // Shared types
    ////////////////////
    typedef logic [8:0]  hpos_t;        // Pixel within the line
    typedef logic [7:0]  vpos_t;        // Line within the frame
    typedef logic [3:0]  color_idx_t;
    typedef logic [11:0] rgb12_t;       // Red in bits 11:8
    typedef logic [3:0]  io_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  cell_addr_t;   // Row * 40 + column
    typedef logic [10:0] glyph_addr_t;  // {code, glyph row}

    ////////////////////
    // Raster timing
    ////////////////////
    localparam int h_active = 320;
    localparam int h_front  = 8;
    localparam int h_sync   = 32;
    localparam int h_back   = 40;
    localparam int h_total  = 400;

    localparam int v_active = 200;
    localparam int v_front  = 4;
    localparam int v_sync   = 4;
    localparam int v_back   = 22;
    localparam int v_total  = 230;

    localparam int text_cols = 40;
    localparam int text_rows = 25;

    ////////////////////
    // IO register map
    ////////////////////
    localparam io_addr_t reg_ctrl    = 4'd0;
    localparam io_addr_t reg_palsel  = 4'd1;
    localparam io_addr_t reg_paldata = 4'd2;
    localparam io_addr_t reg_vline   = 4'd3;
    localparam io_addr_t reg_irqline = 4'd4;
    localparam io_addr_t reg_irqmask = 4'd5;
    localparam io_addr_t reg_irqstat = 4'd6;

endpackage

//--- video_ctrl_if.sv
`timescale 1ns/1ps

interface video_ctrl_if import video_pkg::*; ();

    logic       text_enable;    // ctrl bit 0
    logic [4:0] palsel;         // Entry in 4:1, byte in 0
    logic       pal_wren;
    byte_t      wrdata;         // CPU write data, shared
    byte_t      pal_rddata;

    modport regs (
        output text_enable,
        output palsel,
        output pal_wren,
        output wrdata,
        input  pal_rddata
    );

    modport renderer (input text_enable);

    modport pal (input palsel, input pal_wren, input wrdata, output pal_rddata);

endinterface

//--- dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram import video_pkg::*; #(
    parameter int addr_width = 10
) (
    input  logic                  vclk,

    // CPU port
    input  logic [addr_width-1:0] a_addr,
    input  byte_t                 a_wrdata,
    input  logic                  a_wren,
    output byte_t                 a_rddata,

    // Video port, read only
    input  logic [addr_width-1:0] b_addr,
    output byte_t                 b_rddata
);

    byte_t mem [2**addr_width];

    always_ff @(posedge vclk) begin
        if (a_wren)
            mem[a_addr] <= a_wrdata;
        a_rddata <= mem[a_addr];    // Old data on a write cycle
        b_rddata <= mem[b_addr];
    end

endmodule

//--- raster_timing.sv
`timescale 1ns/1ps

module raster_timing import video_pkg::*; (
    input  logic  vclk,
    input  logic  reset,
    output hpos_t hpos,
    output vpos_t vpos,
    output logic  hsync,
    output logic  vsync,
    output logic  blank,
    output logic  line_end
);

    localparam hpos_t h_last       = hpos_t'(h_total - 1);
    localparam vpos_t v_last       = vpos_t'(v_total - 1);
    localparam hpos_t hsync_start  = hpos_t'(h_active + h_front);
    localparam hpos_t hsync_end    = hpos_t'(h_active + h_front + h_sync);
    localparam vpos_t vsync_start  = vpos_t'(v_active + v_front);
    localparam vpos_t vsync_end    = vpos_t'(v_active + v_front + v_sync);

    hpos_t h_next;
    vpos_t v_next;

    // Next position, outputs are decoded from it so they line up with hpos/vpos
    always_comb begin
        h_next = line_end ? '0 : hpos + hpos_t'(1);
        v_next = vpos;
        if (line_end) begin
            if (vpos == v_last)
                v_next = '0;
            else
                v_next = vpos + vpos_t'(1);
        end
    end

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hpos     <= '0;
            vpos     <= '0;
            hsync    <= 1'b1;   // Syncs idle high
            vsync    <= 1'b1;
            blank    <= 1'b0;
            line_end <= 1'b0;
        end else begin
            hpos     <= h_next;
            vpos     <= v_next;
            line_end <= (h_next == h_last);
            hsync    <= !(h_next >= hsync_start && h_next < hsync_end);
            vsync    <= !(v_next >= vsync_start && v_next < vsync_end);
            blank    <= (h_next >= hpos_t'(h_active)) || (v_next >= vpos_t'(v_active));
        end
    end

endmodule

//--- video_regs.sv
`timescale 1ns/1ps

module video_regs import video_pkg::*; (
    input  logic     vclk,
    input  logic     reset,

    // CPU register bus
    input  io_addr_t io_addr,
    input  byte_t    io_wrdata,
    input  logic     io_wren,
    output byte_t    io_rddata,

    input  vpos_t    vpos,
    output logic     irq,

    video_ctrl_if.regs ctrl
);

    logic       text_enable_r;
    logic [4:0] palsel_r;
    byte_t      irqline_r;
    logic [1:0] irqmask_r;      // {line, vblank}
    logic [1:0] irqstat_r;      // Same layout as the mask

    logic       line_match, line_match_r;
    logic       in_vblank, in_vblank_r;
    logic [1:0] stat_set;
    logic [1:0] stat_clr;

    ////////////////////
    // Interrupt sources
    ////////////////////
    assign line_match = (vpos == irqline_r);
    assign in_vblank  = (vpos >= vpos_t'(v_active));

    // Rising edges only
    assign stat_set = {line_match && !line_match_r, in_vblank && !in_vblank_r};
    assign stat_clr = (io_wren && io_addr == reg_irqstat) ? io_wrdata[1:0] : 2'b00;

    assign irq = |(irqstat_r & irqmask_r);

    ////////////////////
    // Register writes
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            text_enable_r <= 1'b0;
            palsel_r      <= '0;
            irqline_r     <= '0;
            irqmask_r     <= '0;
            irqstat_r     <= '0;
            line_match_r  <= 1'b0;
            in_vblank_r   <= 1'b0;
        end else begin
            line_match_r <= line_match;
            in_vblank_r  <= in_vblank;

            if (io_wren) begin
                case (io_addr)
                    reg_ctrl:    text_enable_r <= io_wrdata[0];
                    reg_palsel:  palsel_r      <= io_wrdata[4:0];
                    reg_irqline: irqline_r     <= io_wrdata;
                    reg_irqmask: irqmask_r     <= io_wrdata[1:0];
                    default: ;
                endcase
            end

            // Set beats a clear in the same cycle
            irqstat_r <= (irqstat_r & ~stat_clr) | stat_set;
        end
    end

    // Palette bytes live in the palette block
    assign ctrl.text_enable = text_enable_r;
    assign ctrl.palsel      = palsel_r;
    assign ctrl.pal_wren    = io_wren && (io_addr == reg_paldata);
    assign ctrl.wrdata      = io_wrdata;

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        case (io_addr)
            reg_ctrl:    io_rddata = {7'b0, text_enable_r};
            reg_palsel:  io_rddata = {3'b0, palsel_r};
            reg_paldata: io_rddata = ctrl.pal_rddata;
            reg_vline:   io_rddata = vpos;
            reg_irqline: io_rddata = irqline_r;
            reg_irqmask: io_rddata = {6'b0, irqmask_r};
            reg_irqstat: io_rddata = {6'b0, irqstat_r};
            default:     io_rddata = '0;    // Unused addresses
        endcase
    end

endmodule

//--- text_renderer.sv
`timescale 1ns/1ps

module text_renderer import video_pkg::*; (
    input  logic        vclk,
    input  logic        reset,
    input  hpos_t       hpos,
    input  vpos_t       vpos,

    video_ctrl_if.renderer ctrl,

    // CPU text memory port, bit 0 picks code or color
    input  logic [10:0] tram_addr,
    input  byte_t       tram_wrdata,
    input  logic        tram_wren,
    output byte_t       tram_rddata,

    // CPU glyph memory port
    input  glyph_addr_t chram_addr,
    input  byte_t       chram_wrdata,
    input  logic        chram_wren,
    output byte_t       chram_rddata,

    output color_idx_t  color_idx
);

    cell_addr_t  cell_r;
    logic [2:0]  row_r1, row_r2;        // Glyph row
    logic [2:0]  col_r1, col_r2, col_r3; // Pixel within the glyph
    logic        tram_sel_r;
    byte_t       code_cpu, color_cpu;
    byte_t       code_vid, color_vid;
    byte_t       color_r3;
    byte_t       glyph_bits;
    glyph_addr_t glyph_addr;
    logic        pixel_on;

    ////////////////////
    // Stage 1, cell address
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            cell_r     <= '0;
            row_r1     <= '0;
            row_r2     <= '0;
            col_r1     <= '0;
            col_r2     <= '0;
            col_r3     <= '0;
            tram_sel_r <= 1'b0;
        end else begin
            cell_r     <= cell_addr_t'(int'(vpos[7:3]) * text_cols + int'(hpos[8:3]));
            row_r1     <= vpos[2:0];
            row_r2     <= row_r1;
            col_r1     <= hpos[2:0];
            col_r2     <= col_r1;
            col_r3     <= col_r2;
            tram_sel_r <= tram_addr[0];     // Follows the one-cycle read
        end
    end

    // Code and color are separate memories sharing the cell index
    dual_port_ram #(.addr_width(10)) code_ram (
        .vclk     (vclk),
        .a_addr   (tram_addr[10:1]),
        .a_wrdata (tram_wrdata),
        .a_wren   (tram_wren && !tram_addr[0]),
        .a_rddata (code_cpu),
        .b_addr   (cell_r),
        .b_rddata (code_vid)
    );

    dual_port_ram #(.addr_width(10)) color_ram (
        .vclk     (vclk),
        .a_addr   (tram_addr[10:1]),
        .a_wrdata (tram_wrdata),
        .a_wren   (tram_wren && tram_addr[0]),
        .a_rddata (color_cpu),
        .b_addr   (cell_r),
        .b_rddata (color_vid)
    );

    assign tram_rddata = tram_sel_r ? color_cpu : code_cpu;

    ////////////////////
    // Stage 2, glyph fetch
    ////////////////////
    assign glyph_addr = {code_vid, row_r2};

    dual_port_ram #(.addr_width(11)) glyph_ram (
        .vclk     (vclk),
        .a_addr   (chram_addr),
        .a_wrdata (chram_wrdata),
        .a_wren   (chram_wren),
        .a_rddata (chram_rddata),
        .b_addr   (glyph_addr),
        .b_rddata (glyph_bits)
    );

    always_ff @(posedge vclk)
        color_r3 <= color_vid;

    // Stage 3, MSB is the leftmost pixel
    assign pixel_on  = glyph_bits[~col_r3];
    assign color_idx = !ctrl.text_enable ? '0 :
                       pixel_on          ? color_r3[7:4] : color_r3[3:0];

endmodule

//--- palette.sv
`timescale 1ns/1ps

module palette import video_pkg::*; (
    input  logic       vclk,
    input  logic       reset,

    video_ctrl_if.pal  ctrl,

    input  color_idx_t color_idx,
    input  logic       blank,       // Already aligned with color_idx
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    rgb12_t     entries [16];
    color_idx_t sel_entry;
    logic       sel_red;            // High byte holds red
    rgb12_t     rgb;

    assign sel_entry = ctrl.palsel[4:1];
    assign sel_red   = ctrl.palsel[0];

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                entries[i] <= '0;
        end else if (ctrl.pal_wren) begin
            if (sel_red)
                entries[sel_entry][11:8] <= ctrl.wrdata[3:0];
            else
                entries[sel_entry][7:0] <= ctrl.wrdata;    // Green and blue
        end
    end

    assign ctrl.pal_rddata = sel_red ? {4'b0, entries[sel_entry][11:8]}
                                     : entries[sel_entry][7:0];

    ////////////////////
    // Output registers
    ////////////////////
    assign rgb = entries[color_idx];

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else begin
            vga_r <= blank ? 4'b0 : rgb[11:8];
            vga_g <= blank ? 4'b0 : rgb[7:4];
            vga_b <= blank ? 4'b0 : rgb[3:0];
        end
    end

endmodule

//--- video_top.sv
`timescale 1ns/1ps

module video_top import video_pkg::*; (
    input  logic        vclk,
    input  logic        reset,

    // CPU register bus
    input  io_addr_t    io_addr,
    input  byte_t       io_wrdata,
    input  logic        io_wren,
    output byte_t       io_rddata,
    output logic        irq,

    // Text memory
    input  logic [10:0] tram_addr,
    input  byte_t       tram_wrdata,
    input  logic        tram_wren,
    output byte_t       tram_rddata,

    // Glyph memory
    input  glyph_addr_t chram_addr,
    input  byte_t       chram_wrdata,
    input  logic        chram_wren,
    output byte_t       chram_rddata,

    // VGA
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b,
    output logic        vga_hsync,
    output logic        vga_vsync
);

    hpos_t      hpos;
    vpos_t      vpos;
    logic       hsync, vsync, blank;
    logic [2:0] hsync_d, vsync_d, blank_d;  // Bit 2 is the third stage
    color_idx_t color_idx;

    video_ctrl_if ctrl_if ();

    raster_timing u_timing (
        .vclk     (vclk),
        .reset    (reset),
        .hpos     (hpos),
        .vpos     (vpos),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank    (blank),
        .line_end ()
    );

    video_regs u_regs (
        .vclk      (vclk),
        .reset     (reset),
        .io_addr   (io_addr),
        .io_wrdata (io_wrdata),
        .io_wren   (io_wren),
        .io_rddata (io_rddata),
        .vpos      (vpos),
        .irq       (irq),
        .ctrl      (ctrl_if.regs)
    );

    text_renderer u_text (
        .vclk         (vclk),
        .reset        (reset),
        .hpos         (hpos),
        .vpos         (vpos),
        .ctrl         (ctrl_if.renderer),
        .tram_addr    (tram_addr),
        .tram_wrdata  (tram_wrdata),
        .tram_wren    (tram_wren),
        .tram_rddata  (tram_rddata),
        .chram_addr   (chram_addr),
        .chram_wrdata (chram_wrdata),
        .chram_wren   (chram_wren),
        .chram_rddata (chram_rddata),
        .color_idx    (color_idx)
    );

    palette u_palette (
        .vclk      (vclk),
        .reset     (reset),
        .ctrl      (ctrl_if.pal),
        .color_idx (color_idx),
        .blank     (blank_d[2]),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    ////////////////////
    // Sync alignment
    ////////////////////
    // Three stages match the renderer, the output register is the fourth
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hsync_d   <= 3'b111;
            vsync_d   <= 3'b111;
            blank_d   <= 3'b111;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            hsync_d   <= {hsync_d[1:0], hsync};
            vsync_d   <= {vsync_d[1:0], vsync};
            blank_d   <= {blank_d[1:0], blank};
            vga_hsync <= hsync_d[2];
            vga_vsync <= vsync_d[2];
        end
    end

endmodule

//--- video_assertions.sv
`timescale 1ns/1ps

module video_assertions import video_pkg::*; (
    input logic       vclk,
    input logic       reset,
    input io_addr_t   io_addr,
    input logic       io_wren,
    input hpos_t      hpos,         // Raster position, four cycles ahead of the pins
    input vpos_t      vpos,
    input logic       vga_hsync,
    input logic [3:0] vga_r,
    input logic [3:0] vga_g,
    input logic [3:0] vga_b,
    input logic       irq
);

    int low_count;
    int fail_count = 0;

    // Consecutive low cycles of hsync
    always_ff @(posedge vclk or posedge reset) begin
        if (reset)
            low_count <= 0;
        else if (!vga_hsync)
            low_count <= low_count + 1;
        else
            low_count <= 0;
    end

    hsync_width: assert property (@(posedge vclk) disable iff (reset)
        $rose(vga_hsync) |-> low_count == h_sync)
        else begin
            fail_count++;
            $error("hsync pulse lasted %0d cycles", low_count);
        end

    // Outside the active area four cycles earlier
    blank_black: assert property (@(posedge vclk) disable iff (reset)
        $past((hpos >= hpos_t'(h_active)) || (vpos >= vpos_t'(v_active)), 4)
            |-> {vga_r, vga_g, vga_b} == 12'h000)
        else begin
            fail_count++;
            $error("rgb not zero outside the active area");
        end

    // A rise follows a new line, a mask write or an irqline write
    irq_source: assert property (@(posedge vclk) disable iff (reset)
        $rose(irq) |-> ($past(vpos) != $past(vpos, 2))
                       || $past(io_wren && io_addr == reg_irqmask)
                       || $past(io_wren && io_addr == reg_irqline, 2))
        else begin
            fail_count++;
            $error("irq rose with no line, mask or irqline event before it");
        end

endmodule

bind video_top video_assertions u_assertions (
    .vclk      (vclk),
    .reset     (reset),
    .io_addr   (io_addr),
    .io_wren   (io_wren),
    .hpos      (hpos),
    .vpos      (vpos),
    .vga_hsync (vga_hsync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .irq       (irq)
);

//--- video_checker.sv
`timescale 1ns/1ps

module video_checker import video_pkg::*; (
    input  logic       vclk,
    input  logic       reset,
    input  byte_t      io_rddata,
    input  logic       irq,
    input  byte_t      tram_rddata,
    input  byte_t      chram_rddata,
    input  logic [3:0] vga_r,
    input  logic [3:0] vga_g,
    input  logic [3:0] vga_b,
    input  logic       vga_hsync,
    input  logic       vga_vsync,

    // Kinds are 0 read, 1 read below bound, 2 irq, 3 pixel, 4 text and 5 glyph readback
    input  logic       req,
    input  logic [2:0] req_kind,
    input  int         req_test,
    input  hpos_t      req_x,
    input  vpos_t      req_y,
    input  rgb12_t     req_exp,
    output int         done_count,
    output int         value_errors,
    output int         sync_errors
);

    int     x, y;
    int     hs_count;       // hsync pulses since the last vsync
    logic   hs_prev, vs_prev;
    logic   locked;
    logic   pending;
    int     pend_test;
    hpos_t  pend_x;
    vpos_t  pend_y;
    rgb12_t pend_exp;
    rgb12_t rgb;

    assign rgb = {vga_r, vga_g, vga_b};

    function automatic string name_of(input int id);
        case (id)
            1:       return "register_access";
            2:       return "line_irq";
            3:       return "vblank_irq";
            4:       return "text_render";
            5:       return "text_disable";
            6:       return "blanking";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input int test, input string what, input int expected,
                                   input int actual);
        $display("error %s %s expected %0h actual %0h", name_of(test), what, expected, actual);
        value_errors++;
    endtask

    ////////////////////
    // Sampling on the falling edge
    ////////////////////
    always @(negedge vclk) begin
        if (reset) begin
            x            = 0;
            y            = 0;
            hs_count     = 0;
            hs_prev      = 1'b1;
            vs_prev      = 1'b1;
            locked       = 1'b0;
            pending      = 1'b0;
            done_count   = 0;
            value_errors = 0;
            sync_errors  = 0;
        end else begin
            // Raster position of the pixel now on the pins
            if (x == h_total - 1) begin
                x = 0;
                y = (y == v_total - 1) ? 0 : y + 1;
            end else begin
                x = x + 1;
            end

            if (hs_prev && !vga_hsync) begin
                if (locked && x != h_active + h_front) begin
                    $display("hsync fell at x %0d on line %0d", x, y);
                    sync_errors++;
                end
                x = h_active + h_front;
                hs_count++;
            end

            if (vs_prev && !vga_vsync) begin
                if (locked && (x != 0 || y != v_active + v_front)) begin
                    $display("vsync fell at x %0d on line %0d", x, y);
                    sync_errors++;
                end
                if (locked && hs_count != v_total) begin
                    $display("frame had %0d hsync pulses instead of %0d", hs_count, v_total);
                    sync_errors++;
                end
                y        = v_active + v_front;
                hs_count = 0;
                locked   = 1'b1;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;

            if (req) begin
                case (req_kind)
                    3'd0: begin
                        if (io_rddata != req_exp[7:0])
                            report_mismatch(req_test, "io_rddata", int'(req_exp[7:0]),
                                            int'(io_rddata));
                        done_count++;
                    end
                    3'd1: begin
                        if (!(io_rddata < req_exp[7:0]))
                            report_mismatch(req_test, "io_rddata below", int'(req_exp[7:0]),
                                            int'(io_rddata));
                        done_count++;
                    end
                    3'd2: begin
                        if (irq != req_exp[0])
                            report_mismatch(req_test, "irq", int'(req_exp[0]), int'(irq));
                        done_count++;
                    end
                    3'd4: begin
                        if (tram_rddata != req_exp[7:0])
                            report_mismatch(req_test, "tram_rddata", int'(req_exp[7:0]),
                                            int'(tram_rddata));
                        done_count++;
                    end
                    3'd5: begin
                        if (chram_rddata != req_exp[7:0])
                            report_mismatch(req_test, "chram_rddata", int'(req_exp[7:0]),
                                            int'(chram_rddata));
                        done_count++;
                    end
                    default: begin
                        pending   = 1'b1;       // Compared when the position comes round
                        pend_test = req_test;
                        pend_x    = req_x;
                        pend_y    = req_y;
                        pend_exp  = req_exp;
                    end
                endcase
            end

            if (pending && locked && x == int'(pend_x) && y == int'(pend_y)) begin
                if (rgb != pend_exp)
                    report_mismatch(pend_test, $sformatf("pixel (%0d,%0d)", x, y),
                                    int'(pend_exp), int'(rgb));
                pending = 1'b0;
                done_count++;
            end
        end
    end

endmodule

//--- tb_video.sv
`timescale 1ns/1ps

module tb_video import video_pkg::*; ();

    logic        vclk;
    logic        reset;
    io_addr_t    io_addr;
    byte_t       io_wrdata;
    logic        io_wren;
    byte_t       io_rddata;
    logic        irq;
    logic [10:0] tram_addr;
    byte_t       tram_wrdata;
    logic        tram_wren;
    byte_t       tram_rddata;
    glyph_addr_t chram_addr;
    byte_t       chram_wrdata;
    logic        chram_wren;
    byte_t       chram_rddata;
    logic [3:0]  vga_r, vga_g, vga_b;
    logic        vga_hsync, vga_vsync;

    // Requests to the checker
    logic        req;
    logic [2:0]  req_kind;
    int          req_test;
    hpos_t       req_x;
    vpos_t       req_y;
    rgb12_t      req_exp;
    int          done_count;
    int          value_errors;
    int          sync_errors;

    int tb_errors;
    int timeout_cycles = 2 * h_total * v_total;     // Two frames

    video_top dut (
        .vclk         (vclk),
        .reset        (reset),
        .io_addr      (io_addr),
        .io_wrdata    (io_wrdata),
        .io_wren      (io_wren),
        .io_rddata    (io_rddata),
        .irq          (irq),
        .tram_addr    (tram_addr),
        .tram_wrdata  (tram_wrdata),
        .tram_wren    (tram_wren),
        .tram_rddata  (tram_rddata),
        .chram_addr   (chram_addr),
        .chram_wrdata (chram_wrdata),
        .chram_wren   (chram_wren),
        .chram_rddata (chram_rddata),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync)
    );

    video_checker u_checker (
        .vclk         (vclk),
        .reset        (reset),
        .io_rddata    (io_rddata),
        .irq          (irq),
        .tram_rddata  (tram_rddata),
        .chram_rddata (chram_rddata),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .req          (req),
        .req_kind     (req_kind),
        .req_test     (req_test),
        .req_x        (req_x),
        .req_y        (req_y),
        .req_exp      (req_exp),
        .done_count   (done_count),
        .value_errors (value_errors),
        .sync_errors  (sync_errors)
    );

    initial begin
        vclk = 1'b0;
        forever #10 vclk = ~vclk;
    end

    ////////////////////
    // Bus tasks
    ////////////////////
    // Drive point is 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge vclk);
        #2;
    endtask

    task automatic bus_write(input int addr, input int data);
        next_cycle();
        io_addr   = io_addr_t'(addr);
        io_wrdata = byte_t'(data);
        io_wren   = 1'b1;
        next_cycle();
        io_wren   = 1'b0;
    endtask

    task automatic mem_write(input logic glyph, input int addr, input int data);
        next_cycle();
        if (glyph) begin
            chram_addr   = glyph_addr_t'(addr);
            chram_wrdata = byte_t'(data);
            chram_wren   = 1'b1;
        end else begin
            tram_addr    = 11'(addr);
            tram_wrdata  = byte_t'(data);
            tram_wren    = 1'b1;
        end
        next_cycle();
        chram_wren = 1'b0;
        tram_wren  = 1'b0;
    endtask

    // Hands one check to the checker and waits until it is done
    task automatic request_check(input logic [2:0] kind, input int test, input int x,
                                 input int y, input int expected);
        int start;
        int waited;
        start = done_count;
        next_cycle();
        req      = 1'b1;
        req_kind = kind;
        req_test = test;
        req_x    = hpos_t'(x);
        req_y    = vpos_t'(y);
        req_exp  = rgb12_t'(expected);
        next_cycle();
        req    = 1'b0;
        waited = 0;
        while (done_count == start && waited < timeout_cycles) begin
            next_cycle();
            waited++;
        end
        if (done_count == start) begin
            $display("timeout, check in test %0d was never completed", test);
            tb_errors++;
        end
    endtask

    task automatic wait_vline(input int test, input int line_no);
        int waited;
        io_addr = reg_vline;
        waited  = 0;
        next_cycle();
        while (io_rddata != byte_t'(line_no) && waited < timeout_cycles) begin
            next_cycle();
            waited++;
        end
        if (io_rddata != byte_t'(line_no)) begin
            $display("timeout, line %0d never came in test %0d", line_no, test);
            tb_errors++;
        end
    endtask

    task automatic wait_irq(input int test);
        int waited;
        waited = 0;
        while (!irq && waited < timeout_cycles) begin
            next_cycle();
            waited++;
        end
        if (!irq) begin
            $display("timeout, irq never rose in test %0d", test);
            tb_errors++;
        end
    endtask

    task automatic run_command(input byte cmd, input int test, input int a, input int b,
                               input int c);
        case (cmd)
            "w": bus_write(a, b);
            "r": begin
                io_addr = io_addr_t'(a);
                request_check(3'd0, test, 0, 0, b);
            end
            "l": begin
                io_addr = io_addr_t'(a);
                request_check(3'd1, test, 0, 0, b);     // Read below a bound
            end
            "q": request_check(3'd2, test, 0, 0, a);
            "t": begin
                mem_write(1'b0, a, b);
                request_check(3'd4, test, 0, 0, b);     // Read back through the CPU port
            end
            "g": begin
                mem_write(1'b1, a, b);
                request_check(3'd5, test, 0, 0, b);
            end
            "p": request_check(3'd3, test, a, b, c);
            "v": wait_vline(test, a);
            "i": begin
                wait_irq(test);
                io_addr = reg_irqstat;
                request_check(3'd0, test, 0, 0, a);
            end
            default: begin
                $display("unknown command %c in the input file", cmd);
                tb_errors++;
            end
        endcase
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int    fd;
        int    n;
        int    total;
        int    test, a, b, c;
        byte   cmd;
        string line;

        reset        = 1'b1;
        io_addr      = '0;
        io_wrdata    = '0;
        io_wren      = 1'b0;
        tram_addr    = '0;
        tram_wrdata  = '0;
        tram_wren    = 1'b0;
        chram_addr   = '0;
        chram_wrdata = '0;
        chram_wren   = 1'b0;
        req          = 1'b0;
        req_kind     = '0;
        req_test     = 0;
        req_x        = '0;
        req_y        = '0;
        req_exp      = '0;
        tb_errors    = 0;
        repeat (3) @(posedge vclk);
        #2;
        reset = 1'b0;

        fd = $fopen("video_input.txt", "r");
        if (fd == 0) begin
            $display("could not open video_input.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                    continue;                   // Blank line or comment
                n = $sscanf(line, "%c %d %h %h %h", cmd, test, a, b, c);
                run_command(cmd, test, a, b, c);
            end
            $fclose(fd);
        end

        total = value_errors + sync_errors + dut.u_assertions.fail_count + tb_errors;
        $display("errors value %0d sync %0d assertion %0d testbench %0d",
                 value_errors, sync_errors, dut.u_assertions.fail_count, tb_errors);
        if (total == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- video_input.txt
# cmd test a b c, test is decimal and the other fields are hex
# w addr data | r addr value | l addr bound | q irq | t,g addr data | p x y rgb | v line | i irqstat
w 1 0 01
r 1 0 01
w 1 1 0b
w 1 2 03
r 1 2 03
w 1 1 0a
w 1 2 c9
r 1 2 c9
r 1 1 0a
w 1 4 32
r 1 4 32
w 1 5 03
r 1 5 03
w 1 5 00
r 1 7 00
r 1 f 00
l 1 3 e6
v 2 0
w 2 6 03
w 2 5 02
i 2 02
r 2 3 32
w 2 6 02
q 2 0
r 2 6 00
w 3 4 ff
w 3 6 03
w 3 5 01
i 3 01
w 3 6 01
q 3 0
i 3 01
w 3 5 00
w 4 1 14
w 4 2 5f
w 4 1 15
w 4 2 0a
w 4 1 00
w 4 2 21
w 4 1 01
w 4 2 07
t 4 0a6 41
t 4 0a7 5a
g 4 208 18
g 4 20b 42
g 4 20c 7e
p 4 18 10 a5f
p 4 1b 10 3c9
p 4 19 13 3c9
p 4 1a 13 a5f
p 4 18 14 a5f
p 4 1e 14 3c9
w 5 0 00
p 5 1b 10 721
p 5 1a 13 721
p 6 13f c7 721
p 6 140 00 000
p 6 14a 0a 000
p 6 000 d7 000

//--- all.f
video_pkg.sv
video_ctrl_if.sv
dual_port_ram.sv
raster_timing.sv
video_regs.sv
text_renderer.sv
palette.sv
video_top.sv
video_assertions.sv
video_checker.sv
tb_video.sv

//--- Makefile
TOP = tb_video

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
